// ==== hdl/radio_ctrl_pkg.sv ====
package radio_ctrl_pkg;

	// ------------------------------------------------------------------------
	// Bus and datapath widths
	// ------------------------------------------------------------------------
	localparam int ADDR_W       = 16;                    // Bus address
	localparam int DATA_W       = 8;                     // Bus data, one byte
	localparam int TX_PAT_W     = 32;                    // I word + Q word with sync bits
	localparam int TX_FRAME_LEN = 16;                    // Cycles per TX frame, 2 bits each
	localparam int TX_CNT_W     = $clog2(TX_FRAME_LEN);  // Frame counter width
	localparam int PROBE_SEL_W  = 8;                     // Probe select code

	// ------------------------------------------------------------------------
	// Register map
	// ------------------------------------------------------------------------
	typedef enum logic [ADDR_W-1:0] {
		REG_SCRATCH0 = 16'h0000,
		REG_SCRATCH1 = 16'h0001,
		REG_SCRATCH2 = 16'h0002,
		REG_STATUS   = 16'h0003, // Lock inputs, read only
		REG_CONTROL  = 16'h0004, // Bit 0 soft reset
		REG_PROBE_A  = 16'h0005,
		REG_PROBE_B  = 16'h0006,
		REG_TX_PAT3  = 16'h0011, // Pattern [31:24], top of I
		REG_TX_PAT2  = 16'h0012,
		REG_TX_PAT1  = 16'h0013,
		REG_TX_PAT0  = 16'h0014, // Pattern [7:0], bottom of Q
		REG_TX_EN    = 16'h0015  // Bit 0 serializer enable
	} reg_addr_e;

	// Debug probe sources, other codes give 0
	typedef enum logic [PROBE_SEL_W-1:0] {
		PROBE_RX_SUBG  = 8'd0,
		PROBE_RX_WIFI  = 8'd1,
		PROBE_TX_FRAME = 8'd2,
		PROBE_TX_MSB   = 8'd3,
		PROBE_BUS_STB  = 8'd4
	} probe_src_e;

	// ------------------------------------------------------------------------
	// Reset values
	// ------------------------------------------------------------------------
	// Sync 10, I 0x3FFE, sync 01, Q 0x3FFF
	localparam logic [TX_PAT_W-1:0] TX_PAT_RESET  = 32'hBFFE_7FFF;
	localparam logic                TX_EN_RESET   = 1'b1;            // Stream on out of reset
	localparam probe_src_e          PROBE_A_RESET = PROBE_RX_SUBG;
	localparam probe_src_e          PROBE_B_RESET = PROBE_TX_FRAME;
	localparam logic [DATA_W-1:0]   RD_UNMAPPED   = 8'hFF;           // Read of a hole in the map

endpackage

// ==== hdl/radio_cfg_if.sv ====
`timescale 1ns/1ns

// Static configuration from the register bank to its users
interface radio_cfg_if;

	logic [radio_ctrl_pkg::TX_PAT_W-1:0]    tx_pattern;  // Loaded once per frame
	logic                                   tx_enable;   // Low forces TX bits to 0
	logic                                   soft_reset;  // Sync clear of datapath
	logic [radio_ctrl_pkg::PROBE_SEL_W-1:0] probe_sel_a;
	logic [radio_ctrl_pkg::PROBE_SEL_W-1:0] probe_sel_b;

	// Register bank side, owns every field
	modport regs (
		output tx_pattern, tx_enable, soft_reset,
		output probe_sel_a, probe_sel_b
	);

	// Consumers, serializer and probe selectors
	modport user (
		input tx_pattern, tx_enable, soft_reset,
		input probe_sel_a, probe_sel_b
	);

endinterface

// ==== hdl/ctrl_regs.sv ====
`timescale 1ns/1ns

module ctrl_regs (
	input  logic                              int_clk_out,
	input  logic                              main_reset_n,
	// Strobe bus from the debug master
	input  logic                              bus_cyc_i,
	input  logic                              bus_stb_i,
	input  logic                              bus_we_i,
	input  logic [radio_ctrl_pkg::ADDR_W-1:0] bus_adr_i,
	input  logic [radio_ctrl_pkg::DATA_W-1:0] bus_wdat_i,
	output logic [radio_ctrl_pkg::DATA_W-1:0] bus_rdat_o,
	output logic                              bus_ack_o,
	// Status inputs
	input  logic                              pll_lock_i,
	input  logic                              aux_lock_i,
	radio_cfg_if.regs                         cfg
);

	logic [radio_ctrl_pkg::DATA_W-1:0] scratch0; // Free for software
	logic [radio_ctrl_pkg::DATA_W-1:0] scratch1;
	logic [radio_ctrl_pkg::DATA_W-1:0] scratch2;
	logic [radio_ctrl_pkg::DATA_W-1:0] rd_mux;   // Read value of the current address
	logic                              bus_req;  // Any cycle with cyc and stb
	logic                              bus_wr;   // Write request
	radio_ctrl_pkg::reg_addr_e         addr;

	assign bus_req = bus_cyc_i && bus_stb_i;
	assign bus_wr  = bus_req && bus_we_i;
	assign addr    = radio_ctrl_pkg::reg_addr_e'(bus_adr_i);

	// ------------------------------------------------------------------------
	// Write decode
	// ------------------------------------------------------------------------
	// Takes effect on the first edge of the write cycle, master holds stb
	// until ack so a repeated write just stores the same byte again
	always_ff @(posedge int_clk_out or negedge main_reset_n) begin
		if (!main_reset_n) begin
			scratch0        <= '0;
			scratch1        <= '0;
			scratch2        <= '0;
			cfg.soft_reset  <= 1'b0;
			cfg.probe_sel_a <= radio_ctrl_pkg::PROBE_A_RESET;
			cfg.probe_sel_b <= radio_ctrl_pkg::PROBE_B_RESET;
			cfg.tx_pattern  <= radio_ctrl_pkg::TX_PAT_RESET;
			cfg.tx_enable   <= radio_ctrl_pkg::TX_EN_RESET;
		end else if (bus_wr) begin
			case (addr)
				radio_ctrl_pkg::REG_SCRATCH0: scratch0 <= bus_wdat_i;
				radio_ctrl_pkg::REG_SCRATCH1: scratch1 <= bus_wdat_i;
				radio_ctrl_pkg::REG_SCRATCH2: scratch2 <= bus_wdat_i;
				radio_ctrl_pkg::REG_CONTROL:  cfg.soft_reset <= bus_wdat_i[0];
				radio_ctrl_pkg::REG_PROBE_A:  cfg.probe_sel_a <= bus_wdat_i;
				radio_ctrl_pkg::REG_PROBE_B:  cfg.probe_sel_b <= bus_wdat_i;
				// Pattern bytes, MSB first in the map
				radio_ctrl_pkg::REG_TX_PAT3:  cfg.tx_pattern[31:24] <= bus_wdat_i;
				radio_ctrl_pkg::REG_TX_PAT2:  cfg.tx_pattern[23:16] <= bus_wdat_i;
				radio_ctrl_pkg::REG_TX_PAT1:  cfg.tx_pattern[15:8] <= bus_wdat_i;
				radio_ctrl_pkg::REG_TX_PAT0:  cfg.tx_pattern[7:0] <= bus_wdat_i;
				radio_ctrl_pkg::REG_TX_EN:    cfg.tx_enable <= bus_wdat_i[0];
				default: begin
					// Status and holes in the map drop the write
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Read mux
	// ------------------------------------------------------------------------
	always_comb begin
		case (addr)
			radio_ctrl_pkg::REG_SCRATCH0: rd_mux = scratch0;
			radio_ctrl_pkg::REG_SCRATCH1: rd_mux = scratch1;
			radio_ctrl_pkg::REG_SCRATCH2: rd_mux = scratch2;
			// Live lock inputs, no capture
			radio_ctrl_pkg::REG_STATUS:   rd_mux = {6'b0, aux_lock_i, pll_lock_i};
			radio_ctrl_pkg::REG_CONTROL:  rd_mux = {7'b0, cfg.soft_reset};
			radio_ctrl_pkg::REG_PROBE_A:  rd_mux = cfg.probe_sel_a;
			radio_ctrl_pkg::REG_PROBE_B:  rd_mux = cfg.probe_sel_b;
			radio_ctrl_pkg::REG_TX_PAT3:  rd_mux = cfg.tx_pattern[31:24];
			radio_ctrl_pkg::REG_TX_PAT2:  rd_mux = cfg.tx_pattern[23:16];
			radio_ctrl_pkg::REG_TX_PAT1:  rd_mux = cfg.tx_pattern[15:8];
			radio_ctrl_pkg::REG_TX_PAT0:  rd_mux = cfg.tx_pattern[7:0];
			radio_ctrl_pkg::REG_TX_EN:    rd_mux = {7'b0, cfg.tx_enable};
			default:                      rd_mux = radio_ctrl_pkg::RD_UNMAPPED;
		endcase
	end

	// ------------------------------------------------------------------------
	// Read data and acknowledge
	// ------------------------------------------------------------------------
	// Both land one edge after the request cycle; read data is sampled every
	// cycle, so it shows the address that was on the bus with the request
	always_ff @(posedge int_clk_out or negedge main_reset_n) begin
		if (!main_reset_n) begin
			bus_rdat_o <= '0;
			bus_ack_o  <= 1'b0;
		end else begin
			bus_rdat_o <= rd_mux;
			bus_ack_o  <= bus_req; // One ack per strobe cycle
		end
	end

endmodule

// ==== hdl/lvds_tx_serializer.sv ====
`timescale 1ns/1ns

module lvds_tx_serializer (
	input  logic        int_clk_out,
	input  logic        main_reset_n,
	radio_cfg_if.user   cfg,
	output logic [1:0]  tx_bits_o,   // Bit pair per cycle, pin polarity
	output logic        tx_frame_o   // Pulse with each pattern load
);

	localparam logic [radio_ctrl_pkg::TX_CNT_W-1:0] CNT_LAST =
		radio_ctrl_pkg::TX_CNT_W'(radio_ctrl_pkg::TX_FRAME_LEN - 1);

	logic [radio_ctrl_pkg::TX_CNT_W-1:0] frame_cnt;
	logic [radio_ctrl_pkg::TX_PAT_W-1:0] shreg;     // Pair to send sits in [31:30]
	logic                                load;

	assign load = (frame_cnt == CNT_LAST); // Last slot of the frame

	// Frame counter and load pulse
	always_ff @(posedge int_clk_out or negedge main_reset_n) begin
		if (!main_reset_n) begin
			frame_cnt  <= '0;
			tx_frame_o <= 1'b0;
		end else if (cfg.soft_reset) begin
			frame_cnt  <= '0; // Restart, first load 16 edges after release
			tx_frame_o <= 1'b0;
		end else begin
			frame_cnt  <= load ? '0 : frame_cnt + 1'b1;
			tx_frame_o <= load;
		end
	end

	// Shift register, two bits out per cycle
	always_ff @(posedge int_clk_out) begin
		if (cfg.soft_reset)
			shreg <= '0;
		else if (load)
			shreg <= cfg.tx_pattern; // Pattern writes show up here
		else
			shreg <= {shreg[radio_ctrl_pkg::TX_PAT_W-3:0], 2'b00};
	end

	// Output pair; board pin is inverted so flip here
	always_ff @(posedge int_clk_out or negedge main_reset_n) begin
		if (!main_reset_n)
			tx_bits_o <= 2'b00;
		else if (!cfg.tx_enable || cfg.soft_reset)
			tx_bits_o <= 2'b00; // Idle line
		else
			tx_bits_o <= ~shreg[radio_ctrl_pkg::TX_PAT_W-1 -: 2];
	end

endmodule

// ==== hdl/probe_mux.sv ====
`timescale 1ns/1ns

module probe_mux (
	input  logic      int_clk_out,
	input  logic      main_reset_n,
	radio_cfg_if.user cfg,
	// Probe sources
	input  logic      rx_subg_i,
	input  logic      rx_wifi_i,
	input  logic      tx_frame_i,
	input  logic      tx_msb_i,
	input  logic      bus_stb_i,
	output logic      probe_a_o,
	output logic      probe_b_o
);

	// Shared decode for both selectors
	function automatic logic pick_src(input logic [radio_ctrl_pkg::PROBE_SEL_W-1:0] code,
	                                  input logic [4:0] src);
		case (radio_ctrl_pkg::probe_src_e'(code))
			radio_ctrl_pkg::PROBE_RX_SUBG:  pick_src = src[0];
			radio_ctrl_pkg::PROBE_RX_WIFI:  pick_src = src[1];
			radio_ctrl_pkg::PROBE_TX_FRAME: pick_src = src[2];
			radio_ctrl_pkg::PROBE_TX_MSB:   pick_src = src[3];
			radio_ctrl_pkg::PROBE_BUS_STB:  pick_src = src[4];
			default:                        pick_src = 1'b0; // Unknown code
		endcase
	endfunction

	logic [4:0] srcs; // Source bus, index is the select code

	assign srcs = {bus_stb_i, tx_msb_i, tx_frame_i, rx_wifi_i, rx_subg_i};

	// One flop per probe, source to pin in one cycle
	always_ff @(posedge int_clk_out or negedge main_reset_n) begin
		if (!main_reset_n) begin
			probe_a_o <= 1'b0;
			probe_b_o <= 1'b0;
		end else begin
			probe_a_o <= pick_src(cfg.probe_sel_a, srcs);
			probe_b_o <= pick_src(cfg.probe_sel_b, srcs);
		end
	end

endmodule

// ==== hdl/radio_ctrl_top.sv ====
`timescale 1ns/1ns

module radio_ctrl_top (
	input  logic                              int_clk_out,
	input  logic                              main_reset_n,
	// Debug register bus
	input  logic                              bus_cyc_i,
	input  logic                              bus_stb_i,
	input  logic                              bus_we_i,
	input  logic [radio_ctrl_pkg::ADDR_W-1:0] bus_adr_i,
	input  logic [radio_ctrl_pkg::DATA_W-1:0] bus_wdat_i,
	output logic [radio_ctrl_pkg::DATA_W-1:0] bus_rdat_o,
	output logic                              bus_ack_o,
	// Status and probe sources
	input  logic                              pll_lock_i,
	input  logic                              aux_lock_i,
	input  logic                              rx_subg_i,
	input  logic                              rx_wifi_i,
	// TX test stream and probe pins
	output logic [1:0]                        tx_bits_o,
	output logic                              tx_frame_o,
	output logic                              probe_a_o,
	output logic                              probe_b_o
);

	radio_cfg_if cfg_if (); // Config fan-out

	ctrl_regs u_regs (
		.int_clk_out  (int_clk_out),
		.main_reset_n (main_reset_n),
		.bus_cyc_i    (bus_cyc_i),
		.bus_stb_i    (bus_stb_i),
		.bus_we_i     (bus_we_i),
		.bus_adr_i    (bus_adr_i),
		.bus_wdat_i   (bus_wdat_i),
		.bus_rdat_o   (bus_rdat_o),
		.bus_ack_o    (bus_ack_o),
		.pll_lock_i   (pll_lock_i),
		.aux_lock_i   (aux_lock_i),
		.cfg          (cfg_if.regs)
	);

	lvds_tx_serializer u_tx_ser (
		.int_clk_out  (int_clk_out),
		.main_reset_n (main_reset_n),
		.cfg          (cfg_if.user),
		.tx_bits_o    (tx_bits_o),
		.tx_frame_o   (tx_frame_o)
	);

	// TX MSB is the first bit of each pair on the pin
	probe_mux u_probe (
		.int_clk_out  (int_clk_out),
		.main_reset_n (main_reset_n),
		.cfg          (cfg_if.user),
		.rx_subg_i    (rx_subg_i),
		.rx_wifi_i    (rx_wifi_i),
		.tx_frame_i   (tx_frame_o),
		.tx_msb_i     (tx_bits_o[1]),
		.bus_stb_i    (bus_stb_i),
		.probe_a_o    (probe_a_o),
		.probe_b_o    (probe_b_o)
	);

endmodule

// ==== testbench/radio_ctrl_props.sv ====
`timescale 1ns/1ns

// Bus and serializer timing rules bound into the register bank and the serializer
module radio_ctrl_props (
	input logic       clk_i,
	input logic       rst_n_i,
	input logic       req_i,     // Cycle with cyc and stb
	input logic       ack_i,
	input logic       frame_i,   // Load pulse
	input logic [1:0] bits_i,
	input logic       enable_i,
	input logic       soft_i     // Soft reset restarts the frame
);

	int fail_cnt = 0; // Failed attempts, summed into the error count

	// ------------------------------------------------------------------------
	// Bus acknowledge
	// ------------------------------------------------------------------------
	ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		req_i |=> ack_i)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("ack missing one cycle after strobe");
		end

	ack_only_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ack_i |-> $past(req_i))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("ack without strobe in the cycle before");
		end

	// ------------------------------------------------------------------------
	// Serializer
	// ------------------------------------------------------------------------
	frame_period: assert property (@(posedge clk_i) disable iff (!rst_n_i || soft_i)
		frame_i |=> ##15 frame_i)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("frame pulses not 16 cycles apart");
		end

	// Output flop follows enable one edge later
	bits_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!enable_i |=> (bits_i == 2'b00))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("tx bits active while disabled");
		end

endmodule

bind ctrl_regs radio_ctrl_props u_regs_props (
	.clk_i    (int_clk_out),
	.rst_n_i  (main_reset_n),
	.req_i    (bus_cyc_i && bus_stb_i),
	.ack_i    (bus_ack_o),
	.frame_i  (1'b0),
	.bits_i   (2'b00),
	.enable_i (1'b1),
	.soft_i   (1'b0)
);

bind lvds_tx_serializer radio_ctrl_props u_ser_props (
	.clk_i    (int_clk_out),
	.rst_n_i  (main_reset_n),
	.req_i    (1'b0),
	.ack_i    (1'b0),
	.frame_i  (tx_frame_o),
	.bits_i   (tx_bits_o),
	.enable_i (cfg.tx_enable),
	.soft_i   (cfg.soft_reset)
);

// ==== testbench/radio_ctrl_tb.sv ====
`timescale 1ns/1ns

module radio_ctrl_tb;

	localparam int RST_CYCLES  = 10;
	localparam int N_OPS       = 200; // Random bus operations
	localparam int N_FRAMES    = 10;  // Frames with new patterns
	localparam int N_PROBE     = 40;  // Probe select changes
	// About 3 cycles per bus op plus frames, probe pairs and slack
	localparam int CYCLE_LIMIT = 2 * (RST_CYCLES + N_OPS * 3 + N_FRAMES * 40 +
		N_PROBE * 12 + 200);

	logic        int_clk_out;
	logic        main_reset_n;
	logic        bus_cyc;
	logic        bus_stb;
	logic        bus_we;
	logic [15:0] bus_adr;
	logic [7:0]  bus_wdat;
	logic        pll_lock = 1'b0;
	logic        aux_lock = 1'b0;
	logic        rx_subg  = 1'b0;
	logic        rx_wifi  = 1'b0;
	logic [7:0]  bus_rdat;
	logic        bus_ack;
	logic [1:0]  tx_bits;
	logic        tx_frame;
	logic        probe_a;
	logic        probe_b;

	integer      seed   = 32'h2ef5;
	integer      errors = 0;
	integer      checks = 0;
	integer      cycles = 0;
	logic        checking = 1'b0; // Continuous compare after reset
	logic [31:0] rnd_in;          // Random source inputs
	logic [31:0] rnd;
	logic [15:0] addr;
	logic [7:0]  rd;
	integer      n;
	logic        seen;

	// ------------------------------------------------------------------------
	// Model state
	// ------------------------------------------------------------------------
	logic [7:0]  m_scr [0:2];
	logic        m_soft;
	logic [7:0]  m_sel_a;
	logic [7:0]  m_sel_b;
	logic [31:0] m_pat;
	logic        m_en;
	logic [3:0]  m_cnt;
	logic [31:0] m_sh;
	logic        m_sh_ok;     // Shift register known after first load
	logic        exp_ack;
	logic [7:0]  exp_rdat;
	logic        exp_frame;
	logic [1:0]  exp_bits;
	logic        exp_bits_ok;
	logic [1:0]  pa;          // {known, value}
	logic [1:0]  pb;

	radio_ctrl_top uut (
		.int_clk_out  (int_clk_out),
		.main_reset_n (main_reset_n),
		.bus_cyc_i    (bus_cyc),
		.bus_stb_i    (bus_stb),
		.bus_we_i     (bus_we),
		.bus_adr_i    (bus_adr),
		.bus_wdat_i   (bus_wdat),
		.bus_rdat_o   (bus_rdat),
		.bus_ack_o    (bus_ack),
		.pll_lock_i   (pll_lock),
		.aux_lock_i   (aux_lock),
		.rx_subg_i    (rx_subg),
		.rx_wifi_i    (rx_wifi),
		.tx_bits_o    (tx_bits),
		.tx_frame_o   (tx_frame),
		.probe_a_o    (probe_a),
		.probe_b_o    (probe_b)
	);

	initial begin
		int_clk_out = 1'b0;
		forever #5 int_clk_out = ~int_clk_out;
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [7:0] read_model(input logic [15:0] a);
		case (a)
			radio_ctrl_pkg::REG_SCRATCH0: read_model = m_scr[0];
			radio_ctrl_pkg::REG_SCRATCH1: read_model = m_scr[1];
			radio_ctrl_pkg::REG_SCRATCH2: read_model = m_scr[2];
			radio_ctrl_pkg::REG_STATUS:   read_model = {6'b0, aux_lock, pll_lock};
			radio_ctrl_pkg::REG_CONTROL:  read_model = {7'b0, m_soft};
			radio_ctrl_pkg::REG_PROBE_A:  read_model = m_sel_a;
			radio_ctrl_pkg::REG_PROBE_B:  read_model = m_sel_b;
			radio_ctrl_pkg::REG_TX_PAT3:  read_model = m_pat[31:24];
			radio_ctrl_pkg::REG_TX_PAT2:  read_model = m_pat[23:16];
			radio_ctrl_pkg::REG_TX_PAT1:  read_model = m_pat[15:8];
			radio_ctrl_pkg::REG_TX_PAT0:  read_model = m_pat[7:0];
			radio_ctrl_pkg::REG_TX_EN:    read_model = {7'b0, m_en};
			default:                      read_model = 8'hFF;
		endcase
	endfunction

	// TX sources come from the model as seen before the edge
	function automatic logic [1:0] probe_model(input logic [7:0] code);
		case (code)
			8'd0:    probe_model = {1'b1, rx_subg};
			8'd1:    probe_model = {1'b1, rx_wifi};
			8'd2:    probe_model = {1'b1, exp_frame};
			8'd3:    probe_model = {exp_bits_ok, exp_bits[1]};
			8'd4:    probe_model = {1'b1, bus_stb};
			default: probe_model = 2'b10;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// Model update from pre-edge values
	// ------------------------------------------------------------------------
	always @(posedge int_clk_out) begin
		if (!main_reset_n) begin
			m_scr[0] = 8'h00;
			m_scr[1] = 8'h00;
			m_scr[2] = 8'h00;
			m_soft = 1'b0;
			m_sel_a = radio_ctrl_pkg::PROBE_A_RESET;
			m_sel_b = radio_ctrl_pkg::PROBE_B_RESET;
			m_pat = radio_ctrl_pkg::TX_PAT_RESET;
			m_en = 1'b1;
			m_cnt = 4'd0;
			m_sh_ok = 1'b0;  // No reset on the shift register
			exp_ack = 1'b0;
			exp_rdat = 8'h00;
			exp_frame = 1'b0;
			exp_bits = 2'b00;
			exp_bits_ok = 1'b1;
			pa = 2'b10;
			pb = 2'b10;
		end else begin
			pa = probe_model(m_sel_a);
			pb = probe_model(m_sel_b);
			if (m_soft) begin
				m_cnt = 4'd0;
				m_sh = 32'h0;
				m_sh_ok = 1'b1;
				exp_frame = 1'b0;
				exp_bits = 2'b00;
				exp_bits_ok = 1'b1;
			end else begin
				exp_bits = m_en ? ~m_sh[31:30] : 2'b00; // Pin is inverted
				exp_bits_ok = !m_en || m_sh_ok;
				exp_frame = (m_cnt == 4'd15);
				if (m_cnt == 4'd15) begin
					m_sh = m_pat;
					m_sh_ok = 1'b1;
					m_cnt = 4'd0;
				end else begin
					m_sh = {m_sh[29:0], 2'b00};
					m_cnt = m_cnt + 4'd1;
				end
			end
			exp_ack = bus_cyc && bus_stb;
			exp_rdat = read_model(bus_adr);
			if (exp_ack && bus_we) begin
				case (bus_adr)
					radio_ctrl_pkg::REG_SCRATCH0: m_scr[0] = bus_wdat;
					radio_ctrl_pkg::REG_SCRATCH1: m_scr[1] = bus_wdat;
					radio_ctrl_pkg::REG_SCRATCH2: m_scr[2] = bus_wdat;
					radio_ctrl_pkg::REG_CONTROL:  m_soft = bus_wdat[0];
					radio_ctrl_pkg::REG_PROBE_A:  m_sel_a = bus_wdat;
					radio_ctrl_pkg::REG_PROBE_B:  m_sel_b = bus_wdat;
					radio_ctrl_pkg::REG_TX_PAT3:  m_pat[31:24] = bus_wdat;
					radio_ctrl_pkg::REG_TX_PAT2:  m_pat[23:16] = bus_wdat;
					radio_ctrl_pkg::REG_TX_PAT1:  m_pat[15:8] = bus_wdat;
					radio_ctrl_pkg::REG_TX_PAT0:  m_pat[7:0] = bus_wdat;
					radio_ctrl_pkg::REG_TX_EN:    m_en = bus_wdat[0];
					default: m_en = m_en;         // Status and holes ignore writes
				endcase
			end
		end
	end

	// Compare in mid cycle when outputs have settled
	always @(negedge int_clk_out) begin
		if (checking) begin
			check_eq(32'(bus_ack), 32'(exp_ack), "bus_ack_o");
			check_eq(32'(bus_rdat), 32'(exp_rdat), "bus_rdat_o");
			check_eq(32'(tx_frame), 32'(exp_frame), "tx_frame_o");
			if (exp_bits_ok)
				check_eq(32'(tx_bits), 32'(exp_bits), "tx_bits_o");
			if (pa[1])
				check_eq(32'(probe_a), 32'(pa[0]), "probe_a_o");
			if (pb[1])
				check_eq(32'(probe_b), 32'(pb[0]), "probe_b_o");
		end
	end

	// Random status and probe source inputs
	always @(posedge int_clk_out) begin
		if (main_reset_n) begin
			rnd_in = $random(seed);
			pll_lock <= rnd_in[0];
			aux_lock <= rnd_in[1];
			rx_subg  <= rnd_in[2];
			rx_wifi  <= rnd_in[3];
		end
	end

	always @(posedge int_clk_out) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Bus tasks
	// ------------------------------------------------------------------------
	task automatic wait_for_ack();
		integer k;
		k = 0;
		do begin
			@(negedge int_clk_out);
			k = k + 1;
		end while (!bus_ack && k < 8);
		if (!bus_ack) begin
			errors = errors + 1;
			$display("No bus ack at %0t ns for address %h", $time, bus_adr);
		end
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge int_clk_out);
		bus_cyc  <= 1'b1;
		bus_stb  <= 1'b1;
		bus_we   <= 1'b1;
		bus_adr  <= a;
		bus_wdat <= d;
		wait_for_ack();
		@(posedge int_clk_out);
		bus_cyc <= 1'b0;
		bus_stb <= 1'b0;
		bus_we  <= 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
		@(posedge int_clk_out);
		bus_cyc <= 1'b1;
		bus_stb <= 1'b1;
		bus_we  <= 1'b0;
		bus_adr <= a;
		wait_for_ack();
		d = bus_rdat;
		@(posedge int_clk_out);
		bus_cyc <= 1'b0;
		bus_stb <= 1'b0;
	endtask

	// Mapped addresses plus a few holes
	task automatic pick_addr(output logic [15:0] a);
		logic [31:0] r;
		r = $random(seed);
		case (r[3:0])
			4'd13:   a = 16'h0007;
			4'd14:   a = 16'h0100;
			4'd15:   a = r[31:16];
			default: a = (r[3:0] < 4'd7) ? {12'h0, r[3:0]} : 16'h000A + {12'h0, r[3:0]};
		endcase
	endtask

	task automatic wait_for_frame();
		integer k;
		k = 0;
		do begin
			@(negedge int_clk_out);
			k = k + 1;
		end while (!tx_frame && k < 40);
		if (!tx_frame) begin
			errors = errors + 1;
			$display("No frame pulse within 40 cycles at %0t ns", $time);
		end
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		bus_cyc = 1'b0;
		bus_stb = 1'b0;
		bus_we = 1'b0;
		bus_adr = 16'h0;
		bus_wdat = 8'h0;
		main_reset_n = 1'b0;
		repeat (RST_CYCLES) @(posedge int_clk_out);
		main_reset_n <= 1'b1;
		@(posedge int_clk_out);
		checking = 1'b1;

		// Reset values
		bus_read(radio_ctrl_pkg::REG_SCRATCH0, rd);
		check_eq(32'(rd), 32'h0, "scratch0 reset");
		bus_read(radio_ctrl_pkg::REG_SCRATCH1, rd);
		check_eq(32'(rd), 32'h0, "scratch1 reset");
		bus_read(radio_ctrl_pkg::REG_SCRATCH2, rd);
		check_eq(32'(rd), 32'h0, "scratch2 reset");
		bus_read(radio_ctrl_pkg::REG_CONTROL, rd);
		check_eq(32'(rd), 32'h0, "control reset");
		bus_read(radio_ctrl_pkg::REG_PROBE_A, rd);
		check_eq(32'(rd), 32'h0, "probe A reset");   // RX sub-GHz source
		bus_read(radio_ctrl_pkg::REG_PROBE_B, rd);
		check_eq(32'(rd), 32'h2, "probe B reset");   // TX frame source
		bus_read(radio_ctrl_pkg::REG_TX_PAT3, rd);
		check_eq(32'(rd), 32'hBF, "pattern byte 3");
		bus_read(radio_ctrl_pkg::REG_TX_PAT2, rd);
		check_eq(32'(rd), 32'hFE, "pattern byte 2");
		bus_read(radio_ctrl_pkg::REG_TX_PAT1, rd);
		check_eq(32'(rd), 32'h7F, "pattern byte 1");
		bus_read(radio_ctrl_pkg::REG_TX_PAT0, rd);
		check_eq(32'(rd), 32'hFF, "pattern byte 0");
		bus_read(radio_ctrl_pkg::REG_TX_EN, rd);
		check_eq(32'(rd), 32'h1, "tx enable reset");
		bus_read(16'h0007, rd);
		check_eq(32'(rd), 32'hFF, "unmapped 0x0007");
		bus_read(16'h0016, rd);
		check_eq(32'(rd), 32'hFF, "unmapped 0x0016");
		bus_read(16'hFFFF, rd);
		check_eq(32'(rd), 32'hFF, "unmapped 0xFFFF");

		// Random register traffic checked every cycle
		repeat (N_OPS) begin
			rnd = $random(seed);
			pick_addr(addr);
			if (rnd[8])
				bus_write(addr, rnd[7:0]);
			else
				bus_read(addr, rd);
		end

		// Stream with a fresh pattern every frame
		bus_write(radio_ctrl_pkg::REG_CONTROL, 8'h00);
		bus_write(radio_ctrl_pkg::REG_TX_EN, 8'h01);
		repeat (N_FRAMES) begin
			wait_for_frame();
			rnd = $random(seed);
			bus_write(radio_ctrl_pkg::REG_TX_PAT3, rnd[31:24]);
			bus_write(radio_ctrl_pkg::REG_TX_PAT2, rnd[23:16]);
			bus_write(radio_ctrl_pkg::REG_TX_PAT1, rnd[15:8]);
			bus_write(radio_ctrl_pkg::REG_TX_PAT0, rnd[7:0]);
		end

		// Line idles while disabled
		bus_write(radio_ctrl_pkg::REG_TX_EN, 8'h00);
		repeat (20) begin
			@(negedge int_clk_out);
			check_eq(32'(tx_bits), 32'h0, "tx bits while disabled");
		end
		bus_write(radio_ctrl_pkg::REG_TX_EN, 8'h01);

		// Soft reset holds the stream, then restarts the frame
		bus_write(radio_ctrl_pkg::REG_CONTROL, 8'h01);
		repeat (20) begin
			@(negedge int_clk_out);
			check_eq(32'(tx_bits), 32'h0, "tx bits in soft reset");
			check_eq(32'(tx_frame), 32'h0, "frame in soft reset");
		end
		bus_write(radio_ctrl_pkg::REG_CONTROL, 8'h00);
		n = 1;      // Already one edge past the release
		seen = 1'b0;
		while (!seen && n < 40) begin
			@(negedge int_clk_out);
			if (tx_frame)
				seen = 1'b1;
			else begin
				@(posedge int_clk_out);
				n = n + 1;
			end
		end
		check_eq(32'(n), 32'd16, "edges from soft reset release to frame");

		// Probe selects where codes 5 to 7 give 0
		repeat (N_PROBE) begin
			rnd = $random(seed);
			bus_write(radio_ctrl_pkg::REG_PROBE_A, rnd[4] ? rnd[15:8] : {5'b0, rnd[2:0]});
			bus_write(radio_ctrl_pkg::REG_PROBE_B, {5'b0, rnd[7:5]});
			repeat (4) @(posedge int_clk_out);
		end

		repeat (4) @(posedge int_clk_out);
		// Bound assertion failures count as errors too
		errors = errors + uut.u_regs.u_regs_props.fail_cnt;
		errors = errors + uut.u_tx_ser.u_ser_props.fail_cnt;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/radio_ctrl_pkg.sv
hdl/radio_cfg_if.sv
hdl/ctrl_regs.sv
hdl/lvds_tx_serializer.sv
hdl/probe_mux.sv
hdl/radio_ctrl_top.sv
testbench/radio_ctrl_props.sv
testbench/radio_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the radio control testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
	--top-module radio_ctrl_tb \
	-f flist.f \
	-o radio_ctrl_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/radio_ctrl_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$SIM_LOG"; then
	exit 1
fi
exit 0
